// File: logic/corr_pkg.sv
// ============================================================================
// Shared definitions for the correlator configuration front end.
// Holds the line count, the command opcodes, the reset values and the
// packed structs passed between the decoder, the line banks and readout.
// Design files import it inside the module body.
// ============================================================================

package corr_pkg;

	localparam int num_lines  = 4;
	localparam int line_idx_w = 8;

	// Command opcodes, carried in the low nibble of a command byte.
	localparam logic [3:0] op_clear          = 4'd0;
	localparam logic [3:0] op_set_line       = 4'd1;
	localparam logic [3:0] op_set_baud       = 4'd3;
	localparam logic [3:0] op_set_voltage    = 4'd4;
	// Delay covers 8 to 11, matched on the upper two opcode bits.
	localparam logic [3:0] op_set_delay      = 4'd8;
	localparam logic [3:0] op_enable_test    = 4'd12;
	localparam logic [3:0] op_enable_capture = 4'd13;

	localparam logic [23:0] rst_increment = 24'd1;
	localparam logic [23:0] rst_cross_len = 24'd1023;
	localparam logic [23:0] rst_auto_len  = 24'd1;

	typedef enum logic [2:0] {
		wr_none,
		wr_clear,
		wr_voltage,
		wr_delay,
		wr_test
	} write_kind_t;

	// One decoded line command, seen by every bank.
	typedef struct packed {
		write_kind_t           kind;
		logic [line_idx_w-1:0] line;
		logic [1:0]            slot;
		logic [3:0]            value;
		logic                  extra;
	} line_write_t;

	typedef struct packed {
		logic [7:0]  voltage_pwm;
		logic [7:0]  test;
		logic [23:0] cross_increment;
		logic [23:0] cross_len;
		logic [23:0] cross_start;
		logic [23:0] auto_increment;
		logic [23:0] auto_len;
		logic [23:0] auto_start;
	} line_cfg_t;

	typedef struct packed {
		logic [3:0] baud_rate;
		logic [7:0] order;
		logic [7:0] current_line;
		logic       integrating;
		logic       external_clock;
		logic       timestamp_reset;
		logic       extra_commands;
	} global_cfg_t;

	localparam line_cfg_t rst_line_cfg = '{
		voltage_pwm:     8'd0,
		test:            8'd0,
		cross_increment: rst_increment,
		cross_len:       rst_cross_len,
		cross_start:     24'd0,
		auto_increment:  rst_increment,
		auto_len:        rst_auto_len,
		auto_start:      24'd0
	};

	localparam global_cfg_t rst_global_cfg = '{
		baud_rate:       4'd0,
		order:           8'd0,
		current_line:    8'd0,
		integrating:     1'b0,
		external_clock:  1'b0,
		timestamp_reset: 1'b1,
		extra_commands:  1'b0
	};

endpackage

// File: logic/cmd_decoder.sv
// ============================================================================
// Command decoder of the configuration front end.
// Takes one strobed command byte per cmd_valid cycle. Global commands update
// the capture settings and the line pointer. Line commands leave as one
// registered line write that every bank sees on the following cycle.
// ============================================================================

module cmd_decoder (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [7:0]              cmd,
	input  logic                    cmd_valid,
	output corr_pkg::global_cfg_t   global_cfg,
	output corr_pkg::line_write_t   line_write
);

	import corr_pkg::*;

	logic [3:0]  opcode;
	logic [3:0]  arg;
	logic        is_delay;
	line_write_t line_write_d;

	assign opcode = cmd[3:0];
	assign arg    = cmd[7:4];

	// Delay commands occupy a block of four opcodes; low bits pick the digit.
	assign is_delay = (opcode[3:2] == op_set_delay[3:2]);

	// Build the next line write. The line and the set selector always follow
	// the global state seen on this edge.
	always_comb begin
		line_write_d       = '0;
		line_write_d.kind  = wr_none;
		line_write_d.line  = global_cfg.current_line;
		line_write_d.extra = global_cfg.extra_commands;
		if (cmd_valid) begin
			if (is_delay) begin
				line_write_d.kind  = wr_delay;
				line_write_d.slot  = opcode[1:0];
				line_write_d.value = {1'b0, arg[2:0]};
			end else begin
				case (opcode)
					op_clear: begin
						line_write_d.kind = wr_clear;
					end
					op_set_voltage: begin
						line_write_d.kind  = wr_voltage;
						line_write_d.slot  = arg[3:2];
						line_write_d.value = {2'b00, arg[1:0]};
					end
					op_enable_test: begin
						line_write_d.kind  = wr_test;
						line_write_d.value = arg;
					end
					default: begin
						line_write_d.kind = wr_none;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			line_write <= '0;
		end else begin
			line_write <= line_write_d;
		end
	end

	// Global settings and the line pointer.
	always_ff @(posedge clk) begin
		if (rst) begin
			global_cfg <= rst_global_cfg;
		end else if (cmd_valid) begin
			case (opcode)
				op_set_line: begin
					global_cfg.current_line[{arg[3:2], 1'b0} +: 2] <= arg[1:0];
				end
				op_set_baud: begin
					// Extra mode reuses this opcode to fill the order field.
					if (global_cfg.extra_commands) begin
						global_cfg.order[{arg[3:2], 1'b0} +: 2] <= arg[1:0];
					end else begin
						global_cfg.baud_rate <= arg;
					end
				end
				op_enable_capture: begin
					global_cfg.integrating     <= arg[0];
					global_cfg.external_clock  <= arg[1];
					global_cfg.timestamp_reset <= arg[2];
					global_cfg.extra_commands  <= arg[3];
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// File: logic/line_config.sv
// ============================================================================
// Register bank of one correlator line.
// Watches the shared line write and applies those addressed to line_index.
// Delay digits land in the half and the set picked by the bank's own test
// bits and by the extra flag carried with the write.
// ============================================================================

module line_config #(
	parameter int line_index = 0
) (
	input  logic                  clk,
	input  logic                  rst,
	input  corr_pkg::line_write_t line_write,
	output corr_pkg::line_cfg_t   cfg
);

	import corr_pkg::*;

	logic       hit;
	logic [1:0] delay_target;
	logic [4:0] half_base;
	logic [4:0] digit_pos;
	logic [2:0] digit;

	assign hit = (line_write.line == line_idx_w'(line_index));

	// Test bits 6:5 pick increment, length or start; bit 4 picks the half.
	assign delay_target = cfg.test[6:5];
	assign half_base    = cfg.test[4] ? 5'd12 : 5'd0;
	assign digit_pos    = half_base + 5'(line_write.slot) * 5'd3;
	assign digit        = line_write.value[2:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg <= rst_line_cfg;
		end else if (hit) begin
			case (line_write.kind)
				wr_clear: begin
					cfg.cross_start <= '0;
					cfg.auto_start  <= '0;
				end
				wr_voltage: begin
					cfg.voltage_pwm[{line_write.slot, 1'b0} +: 2] <= line_write.value[1:0];
				end
				wr_test: begin
					cfg.test[{line_write.extra, 2'b00} +: 4] <= line_write.value;
				end
				wr_delay: begin
					case (delay_target)
						2'd0: begin
							if (line_write.extra) begin
								cfg.auto_increment[digit_pos +: 3] <= digit;
							end else begin
								cfg.cross_increment[digit_pos +: 3] <= digit;
							end
						end
						2'd1: begin
							if (line_write.extra) begin
								cfg.auto_len[digit_pos +: 3] <= digit;
							end else begin
								cfg.cross_len[digit_pos +: 3] <= digit;
							end
						end
						2'd2: begin
							if (line_write.extra) begin
								cfg.auto_start[digit_pos +: 3] <= digit;
							end else begin
								cfg.cross_start[digit_pos +: 3] <= digit;
							end
						end
						default: begin
							// Modes 6 and 7 select nothing.
						end
					endcase
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// File: logic/cfg_readout.sv
// ============================================================================
// Readout of one line's configuration for the sampling logic.
// rd_line picks a bank; its settings appear on rd_cfg one cycle later.
// ============================================================================

module cfg_readout (
	input  logic                clk,
	input  logic                rst,
	input  corr_pkg::line_cfg_t line_cfgs [corr_pkg::num_lines],
	input  logic [1:0]          rd_line,
	output corr_pkg::line_cfg_t rd_cfg
);

	import corr_pkg::*;

	// Register after the mux so the wide select stays out of the sampler path.
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_cfg <= rst_line_cfg;
		end else begin
			rd_cfg <= line_cfgs[rd_line];
		end
	end

endmodule

// File: logic/corr_config_top.sv
// ============================================================================
// Top level of the correlator configuration front end.
// Connects the command decoder, one register bank per line and the readout.
// Commands enter as strobed bytes; settings leave on global_cfg and rd_cfg.
// ============================================================================

module corr_config_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [7:0]            cmd,
	input  logic                  cmd_valid,
	input  logic [1:0]            rd_line,
	output corr_pkg::global_cfg_t global_cfg,
	output corr_pkg::line_cfg_t   rd_cfg
);

	import corr_pkg::*;

	line_write_t line_write;
	line_cfg_t   line_cfgs [num_lines];

	cmd_decoder decoder_i (
		.clk        (clk),
		.rst        (rst),
		.cmd        (cmd),
		.cmd_valid  (cmd_valid),
		.global_cfg (global_cfg),
		.line_write (line_write)
	);

	// One bank per line, each matching its own index.
	for (genvar i = 0; i < num_lines; i++) begin : g_line
		line_config #(
			.line_index (i)
		) line_i (
			.clk        (clk),
			.rst        (rst),
			.line_write (line_write),
			.cfg        (line_cfgs[i])
		);
	end

	cfg_readout readout_i (
		.clk        (clk),
		.rst        (rst),
		.line_cfgs  (line_cfgs),
		.rd_line    (rd_line),
		.rd_cfg     (rd_cfg)
	);

endmodule

// File: bench/corr_config_chk.sv
// ============================================================================
// Concurrent assertions for the correlator configuration front end.
// Bound to corr_config_top from the testbench. Covers reset values, write
// routing to the banks and the one-cycle readout delay.
// fail_count holds the number of failed assertions for the testbench.
// ============================================================================

module corr_config_chk (
	input logic                  clk,
	input logic                  rst,
	input logic                  cmd_valid,
	input logic [1:0]            rd_line,
	input corr_pkg::line_write_t line_write,
	input corr_pkg::line_cfg_t   line_cfgs [corr_pkg::num_lines],
	input corr_pkg::global_cfg_t global_cfg,
	input corr_pkg::line_cfg_t   rd_cfg
);

	import corr_pkg::*;

	int        fail_count = 0;
	line_cfg_t sel_cfg;

	assign sel_cfg = line_cfgs[rd_line];

	reset_state: assert property (@(posedge clk)
		rst |=> (global_cfg == rst_global_cfg && line_write.kind == wr_none &&
			rd_cfg == rst_line_cfg))
	else begin
		$error("Global settings, line write or readout not at reset value");
		fail_count++;
	end

	// Without a strobe the decoder must stay quiet.
	idle_no_write: assert property (@(posedge clk) disable iff (rst)
		!cmd_valid |=> line_write.kind == wr_none)
	else begin
		$error("Line write issued on a cycle without cmd_valid");
		fail_count++;
	end

	readout_delay: assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> rd_cfg == $past(sel_cfg))
	else begin
		$error("rd_cfg is not the selected bank of the previous cycle");
		fail_count++;
	end

	for (genvar i = 0; i < num_lines; i++) begin : g_bank
		bank_reset: assert property (@(posedge clk)
			rst |=> line_cfgs[i] == rst_line_cfg)
		else begin
			$error("Bank %0d not at reset value", i);
			fail_count++;
		end

		// A bank changes only on a write addressed to it.
		bank_routing: assert property (@(posedge clk) disable iff (rst)
			(line_write.line != line_idx_w'(i)) |=> line_cfgs[i] == $past(line_cfgs[i]))
		else begin
			$error("Bank %0d changed on a write to another line", i);
			fail_count++;
		end
	end

endmodule

// File: bench/corr_config_tb.sv
// ============================================================================
// Testbench for the correlator configuration front end.
// Sends directed and LFSR-generated command bytes, keeps a reference model
// of all settings and compares it against global_cfg and a rd_cfg sweep.
// ============================================================================

module corr_config_tb;

	import corr_pkg::*;

	localparam int clk_period     = 40;
	localparam int num_directed   = 64;
	localparam int num_random     = 400;
	localparam int num_cmds       = num_directed + num_random;
	localparam int timeout_cycles = num_cmds * 4 + 200;

	logic        clk;
	logic        rst;
	logic [7:0]  cmd;
	logic        cmd_valid;
	logic [1:0]  rd_line;
	global_cfg_t global_cfg;
	line_cfg_t   rd_cfg;

	global_cfg_t exp_global;
	line_cfg_t   exp_lines [num_lines];
	logic [15:0] lfsr;
	int          err_count;

	corr_config_top dut_i (
		.clk        (clk),
		.rst        (rst),
		.cmd        (cmd),
		.cmd_valid  (cmd_valid),
		.rd_line    (rd_line),
		.global_cfg (global_cfg),
		.rd_cfg     (rd_cfg)
	);

	bind corr_config_top corr_config_chk chk_i (
		.clk        (clk),
		.rst        (rst),
		.cmd_valid  (cmd_valid),
		.rd_line    (rd_line),
		.line_write (line_write),
		.line_cfgs  (line_cfgs),
		.global_cfg (global_cfg),
		.rd_cfg     (rd_cfg)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[6:0], lfsr[15]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic logic [23:0] set_digit(input logic [23:0] f, input int pos,
			input logic [2:0] d);
		logic [23:0] r;
		r = f;
		r[pos +: 3] = d;
		return r;
	endfunction

	// Reference model, applied when the command is strobed.
	task automatic model_cmd(input logic [7:0] b);
		logic [3:0] op;
		logic [3:0] a;
		logic [2:0] mode;
		logic       ext;
		int         pos;
		int         l;
		line_cfg_t  c;
		op  = b[3:0];
		a   = b[7:4];
		ext = exp_global.extra_commands;
		l   = int'(exp_global.current_line);
		pos = 2 * int'(a[3:2]);
		if (op == op_set_line) begin
			exp_global.current_line[pos +: 2] = a[1:0];
		end else if (op == op_set_baud) begin
			if (ext) exp_global.order[pos +: 2] = a[1:0];
			else exp_global.baud_rate = a;
		end else if (op == op_enable_capture) begin
			exp_global.integrating     = a[0];
			exp_global.external_clock  = a[1];
			exp_global.timestamp_reset = a[2];
			exp_global.extra_commands  = a[3];
		end else if (l < num_lines) begin
			c = exp_lines[l];
			if (op == op_clear) begin
				c.cross_start = '0;
				c.auto_start  = '0;
			end else if (op == op_set_voltage) begin
				c.voltage_pwm[pos +: 2] = a[1:0];
			end else if (op == op_enable_test) begin
				c.test[4 * int'(ext) +: 4] = a;
			end else if (op[3:2] == op_set_delay[3:2]) begin
				mode = c.test[6:4];
				pos  = (mode[0] ? 12 : 0) + 3 * int'(op[1:0]);
				case (mode[2:1])
					2'd0: begin
						if (ext) c.auto_increment = set_digit(c.auto_increment, pos, a[2:0]);
						else c.cross_increment = set_digit(c.cross_increment, pos, a[2:0]);
					end
					2'd1: begin
						if (ext) c.auto_len = set_digit(c.auto_len, pos, a[2:0]);
						else c.cross_len = set_digit(c.cross_len, pos, a[2:0]);
					end
					2'd2: begin
						if (ext) c.auto_start = set_digit(c.auto_start, pos, a[2:0]);
						else c.cross_start = set_digit(c.cross_start, pos, a[2:0]);
					end
					default: begin
					end
				endcase
			end
			exp_lines[l] = c;
		end
	endtask

	task automatic strobe(input logic [7:0] b);
		@(posedge clk);
		cmd       <= b;
		cmd_valid <= 1'b1;
		model_cmd(b);
	endtask

	// Gap cycles carry random bytes that the DUT must ignore.
	task automatic idle(input int n);
		logic [7:0] junk;
		repeat (n) begin
			@(posedge clk);
			draw(8, junk);
			cmd       <= junk;
			cmd_valid <= 1'b0;
		end
	endtask

	task automatic check_value(input string name, input logic [175:0] exp,
			input logic [175:0] act);
		if (exp !== act) begin
			$display("ERROR %s: expected %h, got %h", name, exp, act);
			err_count++;
		end
	endtask

	// Global commands must show one cycle after the strobe.
	task automatic strobe_global(input string name, input logic [7:0] b);
		strobe(b);
		idle(1);
		@(negedge clk);
		check_value(name, 176'(exp_global), 176'(global_cfg));
	endtask

	task automatic sweep_lines(input string name);
		idle(3);
		@(negedge clk);
		check_value({name, " global"}, 176'(exp_global), 176'(global_cfg));
		for (int i = 0; i < num_lines; i++) begin
			@(posedge clk);
			rd_line <= 2'(i);
			@(posedge clk);
			@(negedge clk);
			check_value($sformatf("%s line %0d", name, i), exp_lines[i], rd_cfg);
		end
	endtask

	// Mostly valid opcodes on lines 0 to 3, with gaps between strobes.
	task automatic random_cmd();
		logic [7:0] cat;
		logic [7:0] r;
		logic [7:0] s;
		logic [7:0] g;
		logic [7:0] b;
		draw(3, cat);
		draw(4, r);
		draw(2, s);
		draw(2, g);
		case (cat[2:0])
			3'd0: b = {2'b00, r[1:0], op_set_line};
			3'd1: b = {3'b010, s[1:0] == 2'b11, op_set_line};
			3'd2: b = {r[3:0], op_enable_test};
			3'd3, 3'd4: b = {r[3:0], 2'b10, s[1:0]};
			3'd5: b = {r[3:0], op_set_voltage};
			3'd6: b = {r[3:0], s[0] ? op_enable_capture : op_set_baud};
			default: b = {r[3:0], s[0] ? op_clear : {3'b111, s[1]}};
		endcase
		strobe(b);
		if (g[1:0] == 2'd0) idle(2);
		else if (g[1:0] == 2'd1) idle(1);
	endtask

	initial begin
		#(timeout_cycles * clk_period);
		$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		rst        = 1'b1;
		cmd        = '0;
		cmd_valid  = 1'b0;
		rd_line    = '0;
		lfsr       = 16'd45;
		err_count  = 0;
		exp_global = rst_global_cfg;
		for (int i = 0; i < num_lines; i++) exp_lines[i] = rst_line_cfg;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		sweep_lines("reset");

		strobe_global("set_baud", 8'h53);
		strobe_global("capture extra", 8'h9D);
		strobe_global("set_baud order", 8'h63);
		strobe_global("set_line", 8'h21);
		strobe_global("capture off", 8'h0D);

		// Test and voltage on line 2, then voltage on line 1.
		strobe(8'h5C);
		strobe(8'hB4);
		strobe(8'h11);
		strobe(8'h64);
		sweep_lines("test and voltage");

		// Delay modes on line 1, auto set first.
		strobe(8'h8D);
		strobe(8'h2C);
		strobe(8'h78);
		strobe(8'h59);
		strobe(8'h5C);
		strobe(8'h3A);
		strobe(8'h6B);
		strobe(8'h6C);
		strobe(8'h78);
		strobe(8'h7C);
		strobe(8'h79);
		strobe(8'h1C);
		strobe(8'h0D);
		strobe(8'h49);
		strobe(8'h8D);
		strobe(8'h3C);
		strobe(8'h0D);
		strobe(8'hFA);
		// Cross start and increment on line 2.
		strobe(8'h21);
		strobe(8'h8D);
		strobe(8'h4C);
		strobe(8'h0D);
		strobe(8'h2B);
		strobe(8'h8D);
		strobe(8'h0C);
		strobe(8'h0D);
		strobe(8'h58);
		sweep_lines("delay");

		strobe(8'h11);
		strobe(8'h00);
		sweep_lines("clear");

		// Line 5 is beyond the banks.
		strobe(8'h51);
		strobe(8'hFC);
		strobe(8'hF4);
		strobe(8'h00);
		strobe(8'h7B);
		strobe(8'h41);
		sweep_lines("beyond lines");

		strobe(8'h8D);
		strobe(8'h31);
		strobe(8'h4C);
		strobe(8'h58);
		strobe(8'h0D);
		strobe(8'h69);
		sweep_lines("back to back");

		for (int n = 0; n < num_random; n++) begin
			random_cmd();
			if (n % 25 == 24) sweep_lines($sformatf("random %0d", n));
		end
		sweep_lines("final");

		$display("Errors: %0d value mismatches, %0d assertion failures",
			err_count, dut_i.chk_i.fail_count);
		if (err_count == 0 && dut_i.chk_i.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: flist.f
logic/corr_pkg.sv
logic/cmd_decoder.sv
logic/line_config.sv
logic/cfg_readout.sv
logic/corr_config_top.sv
bench/corr_config_chk.sv
bench/corr_config_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the correlator configuration testbench with Verilator and runs it.
# Exits with a failing status when the log reports a failure.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f flist.f \
	--top-module corr_config_tb \
	-o sim_corr_config

# Keep running after a failed assertion so the testbench prints its result.
./obj_dir/sim_corr_config +verilator+error+limit+1000 | tee sim.log

if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"
